// File: run.sh
#!/bin/sh
# build the tile_net_tx testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_tile_net_tx -o sim_tile_net_tx
./obj_dir/sim_tile_net_tx > sim.log 2>&1 || true
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// File: src.f
src/tile_net_pkg.sv
src/return_chan_if.sv
src/eva_translate.sv
src/credit_counter.sv
src/return_fifo.sv
src/load_packer.sv
src/response_dispatch.sv
src/tile_net_tx.sv
tests/tb_tile_net_tx.sv

// File: src/credit_counter.sv
// credit_counter: outstanding request credit count
`timescale 1ns/1ps

module credit_counter
  import tile_net_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic send_i,
  input  logic credit_return_i,
  output logic has_credit_o
);

  logic [credit_width_lp-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= credit_width_lp'(max_out_credits_lp);
    end else if (send_i & ~credit_return_i) begin
      count_r <= count_r - 1'b1;
    end else if (credit_return_i & ~send_i) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign has_credit_o = |count_r;

  // network returns no more credits than were taken
  a_credit_max: assert property (
    @(posedge clk_i) disable iff (reset_i)
    count_r <= credit_width_lp'(max_out_credits_lp)
  );

  a_credit_underflow: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (count_r == '0) |-> !(send_i && !credit_return_i)
  );

endmodule

// File: src/eva_translate.sv
// eva_translate: remote address decode and outgoing packet build
`timescale 1ns/1ps

module eva_translate
  import tile_net_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  remote_req_s                remote_req_i,
  input  logic                       remote_req_v_i,
  output logic                       remote_req_yumi_o,
  input  logic                       has_credit_i,
  input  logic [x_cord_width_lp-1:0] tgo_x_i,
  input  logic [y_cord_width_lp-1:0] tgo_y_i,
  input  logic [x_cord_width_lp-1:0] my_x_i,
  input  logic [y_cord_width_lp-1:0] my_y_i,
  output net_packet_s                out_packet_o,
  output logic                       out_v_o,
  input  logic                       out_ready_i
);

  remote_addr_u eva;
  logic is_dram, is_global, is_group, is_invalid;
  logic [4:0] grp_y_sum;
  logic [5:0] grp_x_sum;

  assign eva = remote_req_i.addr;

  assign is_dram    = eva.dram_view.is_dram;
  assign is_global  = (eva.global_view.remote == 2'b01);
  assign is_group   = (eva.group_view.remote == 3'b001);
  assign is_invalid = ~(is_dram | is_global | is_group);

  // in-group coords are relative to the tile group origin
  assign grp_y_sum = eva.group_view.y_cord + {1'b0, tgo_y_i};
  assign grp_x_sum = eva.group_view.x_cord + {2'b00, tgo_x_i};

  always_comb begin
    out_packet_o.op_ex   = remote_req_i.mask;
    out_packet_o.payload = remote_req_i.payload;
    out_packet_o.src_y   = my_y_i;
    out_packet_o.src_x   = my_x_i;

    if (remote_req_i.swap_aq) out_packet_o.op = op_swap_aq;
    else if (remote_req_i.swap_rl) out_packet_o.op = op_swap_rl;
    else if (remote_req_i.write_not_read) out_packet_o.op = op_store;
    else out_packet_o.op = op_load;

    if (is_dram) begin
      out_packet_o.y_cord = '1;   // dram sits on the last row
      out_packet_o.x_cord = eva.dram_view.x_cord;
      out_packet_o.addr   = pkt_addr_width_lp'(eva.dram_view.ch_addr);
    end else if (is_global) begin
      out_packet_o.y_cord = eva.global_view.y_cord[y_cord_width_lp-1:0];
      out_packet_o.x_cord = eva.global_view.x_cord[x_cord_width_lp-1:0];
      out_packet_o.addr   = eva.global_view.addr;
    end else if (is_group) begin
      out_packet_o.y_cord = grp_y_sum[y_cord_width_lp-1:0];
      out_packet_o.x_cord = grp_x_sum[x_cord_width_lp-1:0];
      out_packet_o.addr   = eva.group_view.addr;
    end else begin
      out_packet_o.y_cord = '0;
      out_packet_o.x_cord = '0;
      out_packet_o.addr   = '0;
    end
  end

  assign out_v_o           = remote_req_v_i & has_credit_i;
  assign remote_req_yumi_o = out_v_o & out_ready_i;

  // core must never issue an address outside the three maps
  a_no_invalid_eva: assert property (
    @(posedge clk_i) disable iff (reset_i) out_v_o |-> !is_invalid
  );

endmodule

// File: src/load_packer.sv
// load_packer: byte and half-word extraction with sign or zero extension
`timescale 1ns/1ps

module load_packer
  import tile_net_pkg::*;
(
  input  logic [data_width_lp-1:0] data_i,
  input  logic                     is_unsigned_i,
  input  logic                     is_byte_i,
  input  logic                     is_hex_i,
  input  logic [1:0]               part_sel_i,
  output logic [data_width_lp-1:0] data_o
);

  logic [7:0]  byte_val;
  logic [15:0] hex_val;

  assign byte_val = data_i[8*part_sel_i +: 8];
  assign hex_val  = data_i[16*part_sel_i[1] +: 16];   // low bit ignored

  always_comb begin
    if (is_byte_i) begin
      if (is_unsigned_i) data_o = {24'b0, byte_val};
      else data_o = {{24{byte_val[7]}}, byte_val};
    end else if (is_hex_i) begin
      if (is_unsigned_i) data_o = {16'b0, hex_val};
      else data_o = {{16{hex_val[15]}}, hex_val};
    end else begin
      data_o = data_i;   // full word
    end
  end

endmodule

// File: src/response_dispatch.sv
// response_dispatch: routes buffered responses to fetch, float or integer paths
`timescale 1ns/1ps

module response_dispatch
  import tile_net_pkg::*;
(
  return_chan_if.cons              chan,
  output logic                         ifetch_v_o,
  output logic [data_width_lp-1:0]     ifetch_instr_o,
  output logic                         float_resp_v_o,
  output logic [reg_addr_width_lp-1:0] float_resp_rd_o,
  output logic [data_width_lp-1:0]     float_resp_data_o,
  output logic                         int_resp_v_o,
  output logic [reg_addr_width_lp-1:0] int_resp_rd_o,
  output logic [data_width_lp-1:0]     int_resp_data_o,
  output logic                         int_resp_force_o,
  input  logic                         int_resp_yumi_i
);

  load_packer packer (
    .data_i        (chan.data),
    .is_unsigned_i (chan.load_info.is_unsigned),
    .is_byte_i     (chan.load_info.is_byte),
    .is_hex_i      (chan.load_info.is_hex),
    .part_sel_i    (chan.load_info.part_sel),
    .data_o        (int_resp_data_o)
  );

  assign ifetch_instr_o    = chan.data;
  assign float_resp_data_o = chan.data;
  assign float_resp_rd_o   = chan.load_info.reg_id;
  assign int_resp_rd_o     = chan.load_info.reg_id;

  always_comb begin
    ifetch_v_o       = 1'b0;
    float_resp_v_o   = 1'b0;
    int_resp_v_o     = 1'b0;
    int_resp_force_o = 1'b0;
    chan.yumi        = 1'b0;
    if (chan.load_info.icache_fetch) begin
      ifetch_v_o = chan.v;
      chan.yumi  = chan.v;
    end else if (chan.load_info.float_wb) begin
      float_resp_v_o = chan.v;
      chan.yumi      = chan.v;
    end else begin
      // full buffer forces the integer writeback so it can drain
      int_resp_v_o     = chan.v;
      int_resp_force_o = chan.v & chan.full;
      chan.yumi        = chan.v & (int_resp_yumi_i | chan.full);
    end
  end

endmodule

// File: src/return_chan_if.sv
// return channel interface between the response buffer and the dispatch logic
`timescale 1ns/1ps

interface return_chan_if
  import tile_net_pkg::*;
();

  logic                     v;
  logic [data_width_lp-1:0] data;
  load_info_s               load_info;
  logic                     full;
  logic                     yumi;   // pop when v & yumi

  modport buffer (
    output v, data, load_info, full,
    input  yumi
  );

  modport cons (
    input  v, data, load_info, full,
    output yumi
  );

endinterface

// File: src/return_fifo.sv
// return_fifo: four-entry buffer of returned data and load info
`timescale 1ns/1ps

module return_fifo
  import tile_net_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  logic [data_width_lp-1:0] data_i,
  input  load_info_s               load_info_i,
  output logic                     ready_o,
  return_chan_if.buffer            chan
);

  logic [data_width_lp-1:0]       data_mem [fifo_depth_lp];
  load_info_s                     info_mem [fifo_depth_lp];
  logic [fifo_ptr_width_lp-1:0]   wptr_r, rptr_r;
  logic [fifo_count_width_lp-1:0] count_r;
  logic push, pop;

  assign chan.full = (count_r == fifo_count_width_lp'(fifo_depth_lp));
  assign ready_o   = ~chan.full;
  assign push      = v_i & ~chan.full;
  assign pop       = chan.v & chan.yumi;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) wptr_r <= wptr_r + 1'b1;   // wraps at depth
      if (pop) rptr_r <= rptr_r + 1'b1;
      if (push & ~pop) count_r <= count_r + 1'b1;
      else if (pop & ~push) count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wptr_r] <= data_i;
      info_mem[wptr_r] <= load_info_i;
    end
  end

  assign chan.v         = (count_r != '0);
  assign chan.data      = data_mem[rptr_r];
  assign chan.load_info = info_mem[rptr_r];

  // consumer only pops a valid head entry
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (reset_i) chan.yumi |-> chan.v
  );

endmodule

// File: src/tile_net_pkg.sv
// tile network localparams, op codes, request, address union, packet and load info types
package tile_net_pkg;

  localparam int data_width_lp         = 32;
  localparam int x_cord_width_lp       = 4;
  localparam int y_cord_width_lp       = 4;
  localparam int pkt_addr_width_lp     = 16;
  localparam int dram_ch_addr_width_lp = 14;
  localparam int max_out_credits_lp    = 8;
  localparam int credit_width_lp       = 4;
  localparam int fifo_depth_lp         = 4;
  localparam int fifo_ptr_width_lp     = $clog2(fifo_depth_lp);
  localparam int fifo_count_width_lp   = $clog2(fifo_depth_lp + 1);
  localparam int reg_addr_width_lp     = 5;

  typedef enum logic [1:0] {
    op_load    = 2'd0,
    op_store   = 2'd1,
    op_swap_aq = 2'd2,
    op_swap_rl = 2'd3
  } packet_op_e;

  typedef struct packed {
    logic                     write_not_read;
    logic                     swap_aq;
    logic                     swap_rl;
    logic [3:0]               mask;
    logic [data_width_lp-1:0] addr;
    logic [data_width_lp-1:0] payload;
  } remote_req_s;

  // one effective address, three decodings
  typedef union packed {
    struct packed {
      logic                             is_dram;
      logic [3:0]                       x_cord;
      logic [12:0]                      unused;
      logic [dram_ch_addr_width_lp-1:0] ch_addr;
    } dram_view;
    struct packed {
      logic [1:0]                   remote;   // 01 for global
      logic [5:0]                   y_cord;
      logic [5:0]                   x_cord;
      logic [pkt_addr_width_lp-1:0] addr;
      logic [1:0]                   byte_sel;
    } global_view;
    struct packed {
      logic [2:0]                   remote;   // 001 for in-group
      logic [4:0]                   y_cord;
      logic [5:0]                   x_cord;
      logic [pkt_addr_width_lp-1:0] addr;
      logic [1:0]                   byte_sel;
    } group_view;
  } remote_addr_u;

  typedef struct packed {
    packet_op_e                   op;
    logic [3:0]                   op_ex;
    logic [pkt_addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0]     payload;
    logic [y_cord_width_lp-1:0]   src_y;
    logic [x_cord_width_lp-1:0]   src_x;
    logic [y_cord_width_lp-1:0]   y_cord;
    logic [x_cord_width_lp-1:0]   x_cord;
  } net_packet_s;

  typedef struct packed {
    logic                         icache_fetch;
    logic                         float_wb;
    logic                         is_unsigned;
    logic                         is_byte;
    logic                         is_hex;
    logic [1:0]                   part_sel;
    logic [reg_addr_width_lp-1:0] reg_id;
  } load_info_s;

  localparam int load_id_width_lp = $bits(load_info_s);

endpackage

// File: src/tile_net_tx.sv
// tile_net_tx: top level of the tile network transmit and return side
`timescale 1ns/1ps

module tile_net_tx
  import tile_net_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         remote_req_v_i,
  input  logic                         remote_req_write_i,
  input  logic                         remote_req_swap_aq_i,
  input  logic                         remote_req_swap_rl_i,
  input  logic [3:0]                   remote_req_mask_i,
  input  logic [data_width_lp-1:0]     remote_req_addr_i,
  input  logic [data_width_lp-1:0]     remote_req_payload_i,
  output logic                         remote_req_yumi_o,
  output net_packet_s                  out_packet_o,
  output logic                         out_v_o,
  input  logic                         out_ready_i,
  input  logic                         credit_return_i,
  input  logic [x_cord_width_lp-1:0]   tgo_x_i,
  input  logic [y_cord_width_lp-1:0]   tgo_y_i,
  input  logic [x_cord_width_lp-1:0]   my_x_i,
  input  logic [y_cord_width_lp-1:0]   my_y_i,
  input  logic                         returned_v_i,
  input  logic [data_width_lp-1:0]     returned_data_i,
  input  logic [load_id_width_lp-1:0]  returned_load_id_i,
  output logic                         returned_ready_o,
  output logic                         ifetch_v_o,
  output logic [data_width_lp-1:0]     ifetch_instr_o,
  output logic                         float_resp_v_o,
  output logic [reg_addr_width_lp-1:0] float_resp_rd_o,
  output logic [data_width_lp-1:0]     float_resp_data_o,
  output logic                         int_resp_v_o,
  output logic [reg_addr_width_lp-1:0] int_resp_rd_o,
  output logic [data_width_lp-1:0]     int_resp_data_o,
  output logic                         int_resp_force_o,
  input  logic                         int_resp_yumi_i
);

  remote_req_s req;
  load_info_s  returned_info;
  logic        has_credit;

  assign req.write_not_read = remote_req_write_i;
  assign req.swap_aq        = remote_req_swap_aq_i;
  assign req.swap_rl        = remote_req_swap_rl_i;
  assign req.mask           = remote_req_mask_i;
  assign req.addr           = remote_req_addr_i;
  assign req.payload        = remote_req_payload_i;
  assign returned_info      = returned_load_id_i;

  return_chan_if chan_if ();

  eva_translate tx (
    .clk_i, .reset_i,
    .remote_req_i (req),
    .remote_req_v_i, .remote_req_yumi_o,
    .has_credit_i (has_credit),
    .tgo_x_i, .tgo_y_i, .my_x_i, .my_y_i,
    .out_packet_o, .out_v_o, .out_ready_i
  );

  credit_counter credits (
    .clk_i, .reset_i,
    .send_i          (remote_req_yumi_o),   // out_v & out_ready
    .credit_return_i,
    .has_credit_o    (has_credit)
  );

  return_fifo rx_fifo (
    .clk_i, .reset_i,
    .v_i         (returned_v_i),
    .data_i      (returned_data_i),
    .load_info_i (returned_info),
    .ready_o     (returned_ready_o),
    .chan        (chan_if)
  );

  response_dispatch dispatch (
    .chan (chan_if),
    .ifetch_v_o, .ifetch_instr_o,
    .float_resp_v_o, .float_resp_rd_o, .float_resp_data_o,
    .int_resp_v_o, .int_resp_rd_o, .int_resp_data_o,
    .int_resp_force_o, .int_resp_yumi_i
  );

endmodule

// File: tests/tb_tile_net_tx.sv
// tile_net_tx testbench with translation, back-pressure, credit, return routing, packing and force tests
`timescale 1ns/1ps

module tb_tile_net_tx
  import tile_net_pkg::*;
();

  localparam int clk_period_lp    = 100;
  localparam int drive_delay_lp   = 10;
  localparam int test_cycles_lp   = 5 + 12 + 5 + 13 + 3 * 3 + 8 * 3 + 9;   // reset, then each test
  localparam int margin_cycles_lp = 50;

  logic clk_i, reset_i;
  logic remote_req_v_i, remote_req_write_i, remote_req_swap_aq_i, remote_req_swap_rl_i;
  logic [3:0] remote_req_mask_i;
  logic [31:0] remote_req_addr_i, remote_req_payload_i;
  logic remote_req_yumi_o;
  net_packet_s out_packet_o;
  logic out_v_o, out_ready_i, credit_return_i;
  logic [3:0] tgo_x_i, tgo_y_i, my_x_i, my_y_i;
  logic returned_v_i, returned_ready_o;
  logic [31:0] returned_data_i;
  logic [load_id_width_lp-1:0] returned_load_id_i;
  logic ifetch_v_o, float_resp_v_o, int_resp_v_o, int_resp_force_o, int_resp_yumi_i;
  logic [31:0] ifetch_instr_o, float_resp_data_o, int_resp_data_o;
  logic [4:0] float_resp_rd_o, int_resp_rd_o;
  logic [31:0] lfsr_r;

  tile_net_tx UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  initial begin
    #((test_cycles_lp + margin_cycles_lp) * clk_period_lp);
    $display("timeout: the tests did not finish in the expected number of cycles");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] res;
    logic fb;
    res = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      res = {res[30:0], fb};
    end
    return res;
  endfunction

  function automatic net_packet_s expected_packet(input logic [31:0] addr,
      input logic wr, input logic aq, input logic rl, input logic [3:0] mask,
      input logic [31:0] payload);
    net_packet_s p;
    p.op_ex   = mask;
    p.payload = payload;
    p.src_x   = my_x_i;
    p.src_y   = my_y_i;
    if (aq) p.op = op_swap_aq;
    else if (rl) p.op = op_swap_rl;
    else if (wr) p.op = op_store;
    else p.op = op_load;
    if (addr[31]) begin   // dram
      p.y_cord = 4'hf;
      p.x_cord = addr[30:27];
      p.addr   = {2'b00, addr[13:0]};
    end else if (addr[31:30] == 2'b01) begin
      p.y_cord = addr[27:24];
      p.x_cord = addr[21:18];
      p.addr   = addr[17:2];
    end else if (addr[31:29] == 3'b001) begin   // relative to group origin
      p.y_cord = addr[27:24] + tgo_y_i;
      p.x_cord = addr[21:18] + tgo_x_i;
      p.addr   = addr[17:2];
    end else begin
      p.y_cord = '0;
      p.x_cord = '0;
      p.addr   = '0;
    end
    return p;
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] w, input logic uns,
      input logic byt, input logic hex, input logic [1:0] sel);
    logic [7:0] b;
    logic [15:0] h;
    case (sel)
      2'd0: b = w[7:0];
      2'd1: b = w[15:8];
      2'd2: b = w[23:16];
      default: b = w[31:24];
    endcase
    h = sel[1] ? w[31:16] : w[15:0];
    if (byt) return uns ? {24'h0, b} : {{24{b[7]}}, b};
    if (hex) return uns ? {16'h0, h} : {{16{h[15]}}, h};
    return w;
  endfunction

  task automatic check_val(input string name, input logic [69:0] got, input logic [69:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #drive_delay_lp;
  endtask

  task automatic settle();
    #40;   // outputs stable by mid cycle
  endtask

  task automatic check_valids(input logic exp_if, input logic exp_fl, input logic exp_int);
    check_val("ifetch_v_o", ifetch_v_o, exp_if);
    check_val("float_resp_v_o", float_resp_v_o, exp_fl);
    check_val("int_resp_v_o", int_resp_v_o, exp_int);
  endtask

  task automatic translate_test();
    logic [31:0] raw;
    logic [3:0] flags;
    int i;
    for (i = 0; i < 12; i++) begin
      raw = lfsr_bits(32);
      case (i % 3)
        0: remote_req_addr_i = {1'b1, raw[30:0]};
        1: remote_req_addr_i = {2'b01, raw[29:0]};
        default: remote_req_addr_i = {3'b001, raw[28:0]};
      endcase
      flags = 4'(lfsr_bits(4));
      remote_req_write_i   = flags[0];
      remote_req_swap_aq_i = flags[1];
      remote_req_swap_rl_i = flags[2];
      remote_req_mask_i    = 4'(lfsr_bits(4));
      remote_req_payload_i = lfsr_bits(32);
      raw = lfsr_bits(16);
      {tgo_x_i, tgo_y_i, my_x_i, my_y_i} = raw[15:0];
      remote_req_v_i = 1'b1;
      settle();
      check_val("out_v_o", out_v_o, 1'b1);
      check_val("remote_req_yumi_o", remote_req_yumi_o, 1'b0);
      check_val("out_packet_o", out_packet_o, expected_packet(remote_req_addr_i,
          remote_req_write_i, remote_req_swap_aq_i, remote_req_swap_rl_i,
          remote_req_mask_i, remote_req_payload_i));
      next_cycle();
    end
    remote_req_v_i = 1'b0;
  endtask

  task automatic backpressure_test();
    int i;
    remote_req_addr_i = {2'b01, 30'(lfsr_bits(30))};
    remote_req_v_i    = 1'b1;
    out_ready_i       = 1'b0;
    for (i = 0; i < 3; i++) begin
      settle();
      check_val("out_v_o", out_v_o, 1'b1);
      check_val("remote_req_yumi_o", remote_req_yumi_o, 1'b0);
      next_cycle();
    end
    out_ready_i     = 1'b1;
    credit_return_i = 1'b1;   // count stays at the full limit
    settle();
    check_val("remote_req_yumi_o", remote_req_yumi_o, 1'b1);
    next_cycle();
    remote_req_v_i  = 1'b0;
    out_ready_i     = 1'b0;
    credit_return_i = 1'b0;
    settle();
    check_val("out_v_o", out_v_o, 1'b0);
    next_cycle();
  endtask

  task automatic credit_test();
    int i;
    remote_req_addr_i = {1'b1, 31'(lfsr_bits(31))};
    remote_req_v_i    = 1'b1;
    out_ready_i       = 1'b1;
    for (i = 0; i < max_out_credits_lp; i++) begin
      settle();
      check_val("out_v_o", out_v_o, 1'b1);
      check_val("remote_req_yumi_o", remote_req_yumi_o, 1'b1);
      next_cycle();
    end
    for (i = 0; i < 2; i++) begin
      settle();
      check_val("out_v_o", out_v_o, 1'b0);
      check_val("remote_req_yumi_o", remote_req_yumi_o, 1'b0);
      next_cycle();
    end
    credit_return_i = 1'b1;
    settle();
    check_val("out_v_o", out_v_o, 1'b0);   // count moves on the next edge
    next_cycle();
    credit_return_i = 1'b0;
    settle();
    check_val("out_v_o", out_v_o, 1'b1);
    next_cycle();
    remote_req_v_i = 1'b0;
    out_ready_i    = 1'b0;
    settle();
    check_val("out_v_o", out_v_o, 1'b0);
    next_cycle();
  endtask

  // pushes one return word, checks it one cycle later, then checks the buffer drained
  task automatic return_one(input logic [31:0] data, input load_info_s info);
    returned_v_i       = 1'b1;
    returned_data_i    = data;
    returned_load_id_i = info;
    settle();
    check_valids(1'b0, 1'b0, 1'b0);
    check_val("returned_ready_o", returned_ready_o, 1'b1);
    next_cycle();
    returned_v_i = 1'b0;
    settle();
    check_valids(info.icache_fetch, !info.icache_fetch && info.float_wb,
        !info.icache_fetch && !info.float_wb);
    if (info.icache_fetch) begin
      check_val("ifetch_instr_o", ifetch_instr_o, data);
    end else if (info.float_wb) begin
      check_val("float_resp_data_o", float_resp_data_o, data);
      check_val("float_resp_rd_o", float_resp_rd_o, info.reg_id);
    end else begin
      check_val("int_resp_rd_o", int_resp_rd_o, info.reg_id);
      check_val("int_resp_force_o", int_resp_force_o, 1'b0);
      check_val("int_resp_data_o", int_resp_data_o, expected_load(data, info.is_unsigned,
          info.is_byte, info.is_hex, info.part_sel));
    end
    next_cycle();
    settle();
    check_valids(1'b0, 1'b0, 1'b0);
    next_cycle();
  endtask

  task automatic return_route_test();
    load_info_s info;
    int kind;
    int_resp_yumi_i = 1'b1;
    for (kind = 0; kind < 3; kind++) begin
      info = '0;
      info.reg_id = 5'(lfsr_bits(5));
      info.icache_fetch = (kind == 0);
      info.float_wb = (kind == 1);
      return_one(lfsr_bits(32), info);
    end
  endtask

  task automatic load_pack_test();
    load_info_s info;
    logic [3:0] sel;
    int i;
    int_resp_yumi_i = 1'b1;
    for (i = 0; i < 8; i++) begin
      sel = 4'(lfsr_bits(4));
      info = '0;
      info.is_byte = sel[0];
      info.is_hex = ~sel[0];
      info.is_unsigned = sel[1];
      info.part_sel = sel[3:2];
      info.reg_id = 5'(lfsr_bits(5));
      return_one(lfsr_bits(32), info);
    end
  endtask

  task automatic force_drain_test();
    logic [31:0] sent [$];
    load_info_s info;
    int i;
    int_resp_yumi_i = 1'b0;
    info = '0;
    info.reg_id = 5'd7;
    for (i = 0; i < fifo_depth_lp; i++) begin
      sent.push_back(lfsr_bits(32));
      returned_v_i       = 1'b1;
      returned_data_i    = sent[i];
      returned_load_id_i = info;
      settle();
      check_val("returned_ready_o", returned_ready_o, 1'b1);
      check_val("int_resp_force_o", int_resp_force_o, 1'b0);
      next_cycle();
    end
    returned_v_i = 1'b0;
    settle();
    check_val("returned_ready_o", returned_ready_o, 1'b0);
    check_val("int_resp_force_o", int_resp_force_o, 1'b1);
    check_val("int_resp_v_o", int_resp_v_o, 1'b1);
    check_val("int_resp_data_o", int_resp_data_o, sent[0]);
    next_cycle();
    int_resp_yumi_i = 1'b1;   // rest drains by the core's own yumi
    for (i = 1; i < fifo_depth_lp; i++) begin
      settle();
      check_val("returned_ready_o", returned_ready_o, 1'b1);
      check_val("int_resp_force_o", int_resp_force_o, 1'b0);
      check_val("int_resp_v_o", int_resp_v_o, 1'b1);
      check_val("int_resp_data_o", int_resp_data_o, sent[i]);
      next_cycle();
    end
    settle();
    check_val("int_resp_v_o", int_resp_v_o, 1'b0);
    next_cycle();
  endtask

  initial begin
    lfsr_r               = 32'd71042;
    reset_i              = 1'b1;
    remote_req_v_i       = 1'b0;
    remote_req_write_i   = 1'b0;
    remote_req_swap_aq_i = 1'b0;
    remote_req_swap_rl_i = 1'b0;
    remote_req_mask_i    = '0;
    remote_req_addr_i    = '0;
    remote_req_payload_i = '0;
    out_ready_i          = 1'b0;
    credit_return_i      = 1'b0;
    tgo_x_i              = '0;
    tgo_y_i              = '0;
    my_x_i               = '0;
    my_y_i               = '0;
    returned_v_i         = 1'b0;
    returned_data_i      = '0;
    returned_load_id_i   = '0;
    int_resp_yumi_i      = 1'b0;
    repeat (4) @(posedge clk_i);
    #drive_delay_lp;
    reset_i = 1'b0;
    settle();
    check_val("out_v_o", out_v_o, 1'b0);
    check_val("returned_ready_o", returned_ready_o, 1'b1);
    check_valids(1'b0, 1'b0, 1'b0);
    check_val("int_resp_force_o", int_resp_force_o, 1'b0);
    next_cycle();
    translate_test();
    backpressure_test();
    credit_test();
    return_route_test();
    load_pack_test();
    force_drain_test();
    $display("PASS: all tests");
    $finish;
  end

endmodule
